/* decoder_pkg.sv */
package decoder_pkg;

    // Surface-code geometry of the decoder array
    localparam int CODE_DISTANCE_X = 5;
    localparam int CODE_DISTANCE_Z = 4;

    localparam int MEASUREMENT_ROUNDS =
        (CODE_DISTANCE_X > CODE_DISTANCE_Z) ? CODE_DISTANCE_X : CODE_DISTANCE_Z;

    localparam int PER_DIMENSION_WIDTH = $clog2(MEASUREMENT_ROUNDS);  // Bits per coordinate

    // A PU is addressed by its round, row and column coordinates
    localparam int ADDRESS_WIDTH = PER_DIMENSION_WIDTH * 3;

endpackage

/* msg_pkg.sv */
package msg_pkg;

    typedef logic [decoder_pkg::ADDRESS_WIDTH-1:0] pu_addr_t;

    // Direct message exchanged between processing units
    typedef struct packed {
        pu_addr_t receiver;
        logic     is_odd_root;        // Sender root has odd cardinality
        logic     touching_boundary;  // Sender cluster touches the boundary
    } direct_msg_t;

    typedef enum logic {
        CH_NEIGHBOR = 1'b0,
        CH_BLOCKING = 1'b1
    } msg_channel_t;

    // Word on the master stream with its channel tag in the top bit
    typedef struct packed {
        msg_channel_t channel;
        direct_msg_t  msg;
    } master_word_t;

    localparam int MASTER_FIFO_DEPTH = 16;
    localparam int FIFO_COUNT_WIDTH  = $clog2(MASTER_FIFO_DEPTH + 1);  // Holds 0 to full

endpackage

/* direct_msg_if.sv */
`timescale 1ns/1ps

interface direct_msg_if (
    input logic clk,
    input logic rst_n
);

    msg_pkg::pu_addr_t receiver_addr;
    logic              is_odd_root;
    logic              touching_boundary;
    logic              valid;
    logic              ready;

    modport sender (
        input  clk,
        input  rst_n,
        output receiver_addr,
        output is_odd_root,
        output touching_boundary,
        output valid,
        input  ready
    );

    modport receiver (
        input  clk,
        input  rst_n,
        input  receiver_addr,
        input  is_odd_root,
        input  touching_boundary,
        input  valid,
        output ready
    );

endinterface

/* fifo_fwft.sv */
`timescale 1ns/1ps

module fifo_fwft (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  msg_pkg::master_word_t din,
    output logic                  full,
    input  logic                  rd_en,
    output msg_pkg::master_word_t dout,
    output logic                  empty
);

    typedef logic [$clog2(msg_pkg::MASTER_FIFO_DEPTH)-1:0] ptr_t;

    msg_pkg::master_word_t                  mem [msg_pkg::MASTER_FIFO_DEPTH];
    ptr_t                                   wr_ptr;
    ptr_t                                   rd_ptr;
    logic [msg_pkg::FIFO_COUNT_WIDTH-1:0]   count;
    logic                                   do_write;
    logic                                   do_read;

    function automatic ptr_t next_ptr(input ptr_t ptr);
        if (ptr == ptr_t'(msg_pkg::MASTER_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (count == msg_pkg::FIFO_COUNT_WIDTH'(msg_pkg::MASTER_FIFO_DEPTH));
    assign empty    = (count == '0);
    assign do_write = wr_en && !full;  // A write into a full buffer is dropped here
    assign do_read  = rd_en && !empty;
    assign dout     = mem[rd_ptr];     // Head entry is always visible

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The producer must see full before it writes
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        full |-> !wr_en
    ) else $error("fifo_fwft write while full");

    // The consumer must see empty before it pops
    a_no_read_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        empty |-> !rd_en
    ) else $error("fifo_fwft read while empty");

endmodule

/* msg_skid.sv */
`timescale 1ns/1ps

module msg_skid (
    input  logic                 clk,
    input  logic                 rst_n,
    input  msg_pkg::direct_msg_t pu_data,
    input  logic                 pu_valid,
    output logic                 pu_ready,
    direct_msg_if.sender         link
);

    msg_pkg::direct_msg_t main_data;
    msg_pkg::direct_msg_t spill_data;
    logic                 main_valid;
    logic                 spill_valid;
    logic                 main_free;
    logic                 pu_fire;

    assign pu_ready  = !spill_valid;  // Registered so the PU never sees link.ready
    assign pu_fire   = pu_valid && pu_ready;
    assign main_free = !main_valid || link.ready;

    assign link.receiver_addr     = main_data.receiver;
    assign link.is_odd_root       = main_data.is_odd_root;
    assign link.touching_boundary = main_data.touching_boundary;
    assign link.valid             = main_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_valid  <= 1'b0;
            spill_valid <= 1'b0;
        end else if (main_free) begin
            main_valid  <= spill_valid || pu_fire;  // Spill goes first to keep order
            spill_valid <= 1'b0;
        end else if (pu_fire) begin
            spill_valid <= 1'b1;                    // Late ready drop lands here
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            main_data <= spill_valid ? spill_data : pu_data;
        end
        if (!main_free && pu_fire) begin
            spill_data <= pu_data;
        end
    end

    // A stalled message on the link must not change until it is taken
    a_link_stable: assert property (
        @(posedge link.clk) disable iff (!link.rst_n)
        link.valid && !link.ready |=>
            link.valid &&
            $stable({link.receiver_addr, link.is_odd_root, link.touching_boundary})
    ) else $error("msg_skid link changed while stalled");

endmodule

/* pu_arbitration_unit.sv */
`timescale 1ns/1ps

module pu_arbitration_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    direct_msg_if.receiver        neighbor_out,
    direct_msg_if.receiver        blocking_out,
    output msg_pkg::direct_msg_t  neighbor_in_data,
    output logic                  neighbor_in_valid,
    input  logic                  neighbor_in_ready,
    output msg_pkg::direct_msg_t  blocking_in_data,
    output logic                  blocking_in_valid,
    input  logic                  blocking_in_ready,
    output msg_pkg::master_word_t master_out_data,
    output logic                  master_out_valid,
    input  logic                  master_out_ready,
    input  msg_pkg::master_word_t master_in_data,
    input  logic                  master_in_valid,
    output logic                  master_in_ready,
    output logic                  has_flying_messages
);

    msg_pkg::direct_msg_t  neighbor_msg;
    msg_pkg::direct_msg_t  blocking_msg;
    msg_pkg::master_word_t out_word;
    logic                  out_wr;
    logic                  out_full;
    logic                  out_empty;
    msg_pkg::master_word_t in_head;
    logic                  in_wr;
    logic                  in_rd;
    logic                  in_full;
    logic                  in_empty;

    assign neighbor_msg = '{
        receiver:          neighbor_out.receiver_addr,
        is_odd_root:       neighbor_out.is_odd_root,
        touching_boundary: neighbor_out.touching_boundary
    };
    assign blocking_msg = '{
        receiver:          blocking_out.receiver_addr,
        is_odd_root:       blocking_out.is_odd_root,
        touching_boundary: blocking_out.touching_boundary
    };

    always_comb begin
        neighbor_out.ready = 1'b0;
        blocking_out.ready = 1'b0;
        out_word.channel   = msg_pkg::CH_BLOCKING;
        out_word.msg       = blocking_msg;
        if (!out_full) begin
            if (neighbor_out.valid) begin  // Neighbor messages win every tie
                neighbor_out.ready = 1'b1;
                out_word.channel   = msg_pkg::CH_NEIGHBOR;
                out_word.msg       = neighbor_msg;
            end else if (blocking_out.valid) begin
                blocking_out.ready = 1'b1;
            end
        end
    end

    assign out_wr           = neighbor_out.ready || blocking_out.ready;
    assign master_out_valid = !out_empty;

    fifo_fwft out_fifo_i (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (out_wr),
        .din   (out_word),
        .full  (out_full),
        .rd_en (master_out_ready && !out_empty),
        .dout  (master_out_data),
        .empty (out_empty)
    );

    assign master_in_ready = !in_full;
    assign in_wr           = master_in_valid && !in_full;

    fifo_fwft in_fifo_i (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (in_wr),
        .din   (master_in_data),
        .full  (in_full),
        .rd_en (in_rd),
        .dout  (in_head),
        .empty (in_empty)
    );

    assign neighbor_in_data = in_head.msg;
    assign blocking_in_data = in_head.msg;

    // The head tag steers the word and only its channel may pop it
    always_comb begin
        neighbor_in_valid = 1'b0;
        blocking_in_valid = 1'b0;
        in_rd             = 1'b0;
        if (!in_empty) begin
            if (in_head.channel == msg_pkg::CH_NEIGHBOR) begin
                neighbor_in_valid = 1'b1;
                in_rd             = neighbor_in_ready;
            end else begin
                blocking_in_valid = 1'b1;
                in_rd             = blocking_in_ready;
            end
        end
    end

    // Spill entries sit behind a valid main register so the skid valids cover them
    assign has_flying_messages = neighbor_out.valid || blocking_out.valid ||
                                 !out_empty || !in_empty;

endmodule

/* pu_link_top.sv */
`timescale 1ns/1ps

module pu_link_top (
    input  logic                  clk,
    input  logic                  rst_n,

    input  msg_pkg::direct_msg_t  neighbor_out_data,
    input  logic                  neighbor_out_valid,
    output logic                  neighbor_out_ready,

    input  msg_pkg::direct_msg_t  blocking_out_data,
    input  logic                  blocking_out_valid,
    output logic                  blocking_out_ready,

    output msg_pkg::direct_msg_t  neighbor_in_data,
    output logic                  neighbor_in_valid,
    input  logic                  neighbor_in_ready,

    output msg_pkg::direct_msg_t  blocking_in_data,
    output logic                  blocking_in_valid,
    input  logic                  blocking_in_ready,

    output msg_pkg::master_word_t master_out_data,
    output logic                  master_out_valid,
    input  logic                  master_out_ready,

    input  msg_pkg::master_word_t master_in_data,
    input  logic                  master_in_valid,
    output logic                  master_in_ready,

    output logic                  has_flying_messages
);

    direct_msg_if neighbor_link (.clk(clk), .rst_n(rst_n));
    direct_msg_if blocking_link (.clk(clk), .rst_n(rst_n));

    msg_skid neighbor_skid_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pu_data  (neighbor_out_data),
        .pu_valid (neighbor_out_valid),
        .pu_ready (neighbor_out_ready),
        .link     (neighbor_link.sender)
    );

    msg_skid blocking_skid_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pu_data  (blocking_out_data),
        .pu_valid (blocking_out_valid),
        .pu_ready (blocking_out_ready),
        .link     (blocking_link.sender)
    );

    pu_arbitration_unit arbitration_unit_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .neighbor_out        (neighbor_link.receiver),
        .blocking_out        (blocking_link.receiver),
        .neighbor_in_data    (neighbor_in_data),
        .neighbor_in_valid   (neighbor_in_valid),
        .neighbor_in_ready   (neighbor_in_ready),
        .blocking_in_data    (blocking_in_data),
        .blocking_in_valid   (blocking_in_valid),
        .blocking_in_ready   (blocking_in_ready),
        .master_out_data     (master_out_data),
        .master_out_valid    (master_out_valid),
        .master_out_ready    (master_out_ready),
        .master_in_data      (master_in_data),
        .master_in_valid     (master_in_valid),
        .master_in_ready     (master_in_ready),
        .has_flying_messages (has_flying_messages)
    );

endmodule

/* tb_pu_link.sv */
`timescale 1ns/1ps

module tb_pu_link;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int BP_CYCLES    = 32;
    localparam int HEAD_WORDS   = msg_pkg::MASTER_FIFO_DEPTH;  // Exactly fills the inbound FIFO
    localparam int RANDOM_MSGS  = 60;
    localparam int TOTAL_MSGS   = 4 + 2 * BP_CYCLES + HEAD_WORDS + 3 * RANDOM_MSGS;
    localparam int WATCHDOG_NS  = TOTAL_MSGS * 20 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    logic                  clk;
    logic                  rst_n;
    msg_pkg::direct_msg_t  neighbor_out_data;
    logic                  neighbor_out_valid;
    logic                  neighbor_out_ready;
    msg_pkg::direct_msg_t  blocking_out_data;
    logic                  blocking_out_valid;
    logic                  blocking_out_ready;
    msg_pkg::direct_msg_t  neighbor_in_data;
    logic                  neighbor_in_valid;
    logic                  neighbor_in_ready;
    msg_pkg::direct_msg_t  blocking_in_data;
    logic                  blocking_in_valid;
    logic                  blocking_in_ready;
    msg_pkg::master_word_t master_out_data;
    logic                  master_out_valid;
    logic                  master_out_ready;
    msg_pkg::master_word_t master_in_data;
    logic                  master_in_valid;
    logic                  master_in_ready;
    logic                  has_flying_messages;

    msg_pkg::direct_msg_t  out_nb_q[$];
    msg_pkg::direct_msg_t  out_bk_q[$];
    msg_pkg::direct_msg_t  in_nb_q[$];
    msg_pkg::direct_msg_t  in_bk_q[$];
    msg_pkg::direct_msg_t  exp_nb_msg;
    msg_pkg::direct_msg_t  exp_bk_msg;
    msg_pkg::direct_msg_t  exp_in_nb_msg;
    msg_pkg::direct_msg_t  exp_in_bk_msg;
    logic                  exp_nb_valid;
    logic                  exp_bk_valid;
    logic                  exp_in_nb_valid;
    logic                  exp_in_bk_valid;
    int                    in_count;
    int                    in_flight;
    logic [31:0]           lfsr_state;
    logic                  idle_phase;
    logic                  expect_neighbor_head;
    logic                  latency_probe;
    logic                  bp_check;
    logic                  head_hold;

    pu_link_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                   input logic [31:0] actual);
        abort_run($sformatf("[ERROR] %0t %s expected 0x%0h actual 0x%0h",
                            $time, sig, expected, actual));
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);  // One step per bit taken
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic msg_pkg::direct_msg_t random_msg();
        logic [31:0] bits;
        bits = take_bits(11);
        return bits[10:0];
    endfunction

    function automatic msg_pkg::master_word_t random_word();
        logic [31:0] bits;
        bits = take_bits(12);
        return bits[11:0];
    endfunction

    // Assumes both skids are empty so the pair is taken on the next edge
    task automatic send_outbound_pair(input logic use_nb, input logic use_bk);
        @(negedge clk);
        neighbor_out_valid = use_nb;
        neighbor_out_data  = random_msg();
        blocking_out_valid = use_bk;
        blocking_out_data  = random_msg();
        @(posedge clk);
        @(negedge clk);
        neighbor_out_valid = 1'b0;
        blocking_out_valid = 1'b0;
    endtask

    task automatic send_inbound_word(input msg_pkg::master_word_t word);
        @(negedge clk);
        master_in_valid = 1'b1;
        master_in_data  = word;
        do @(posedge clk); while (!master_in_ready);
    endtask

    task automatic run_random_traffic(input int n_nb, input int n_bk, input int n_in);
        int   nb_left;
        int   bk_left;
        int   in_left;
        logic nb_fire;
        logic bk_fire;
        logic in_fire;
        nb_left = n_nb;
        bk_left = n_bk;
        in_left = n_in;
        while (nb_left > 0 || bk_left > 0 || in_left > 0 ||
               neighbor_out_valid || blocking_out_valid || master_in_valid) begin
            @(posedge clk);
            nb_fire = neighbor_out_valid && neighbor_out_ready;
            bk_fire = blocking_out_valid && blocking_out_ready;
            in_fire = master_in_valid && master_in_ready;
            @(negedge clk);
            if (nb_fire || !neighbor_out_valid) begin  // Pending messages hold until taken
                neighbor_out_valid = nb_left > 0 && take_bits(1) == 32'd1;
                if (neighbor_out_valid) begin
                    neighbor_out_data = random_msg();
                    nb_left--;
                end
            end
            if (bk_fire || !blocking_out_valid) begin
                blocking_out_valid = bk_left > 0 && take_bits(1) == 32'd1;
                if (blocking_out_valid) begin
                    blocking_out_data = random_msg();
                    bk_left--;
                end
            end
            if (in_fire || !master_in_valid) begin
                master_in_valid = in_left > 0 && take_bits(1) == 32'd1;
                if (master_in_valid) begin
                    master_in_data = random_word();
                    in_left--;
                end
            end
            master_out_ready  = take_bits(2) != 32'd0;
            neighbor_in_ready = take_bits(1) == 32'd1;
            blocking_in_ready = take_bits(1) == 32'd1;
        end
    endtask

    task automatic wait_for_drain();
        master_out_ready  = 1'b1;
        neighbor_in_ready = 1'b1;
        blocking_in_ready = 1'b1;
        while (in_flight != 0 || has_flying_messages) begin
            @(negedge clk);
        end
    endtask

    // Scoreboard bookkeeping sees the values that were stable before each edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (master_out_valid && master_out_ready) begin
                expect_neighbor_head = 1'b0;
                if (master_out_data.channel == msg_pkg::CH_NEIGHBOR && out_nb_q.size() > 0) begin
                    void'(out_nb_q.pop_front());
                end else if (master_out_data.channel == msg_pkg::CH_BLOCKING &&
                             out_bk_q.size() > 0) begin
                    void'(out_bk_q.pop_front());
                end
            end
            if (neighbor_in_valid && neighbor_in_ready && in_nb_q.size() > 0) begin
                void'(in_nb_q.pop_front());
            end
            if (blocking_in_valid && blocking_in_ready && in_bk_q.size() > 0) begin
                void'(in_bk_q.pop_front());
            end
            if (neighbor_out_valid && neighbor_out_ready) begin
                out_nb_q.push_back(neighbor_out_data);
            end
            if (blocking_out_valid && blocking_out_ready) begin
                out_bk_q.push_back(blocking_out_data);
            end
            if (master_in_valid && master_in_ready) begin
                if (master_in_data.channel == msg_pkg::CH_NEIGHBOR) begin
                    in_nb_q.push_back(master_in_data.msg);
                end else begin
                    in_bk_q.push_back(master_in_data.msg);
                end
            end
            exp_nb_valid    = out_nb_q.size() > 0;
            exp_nb_msg      = exp_nb_valid ? out_nb_q[0] : '0;
            exp_bk_valid    = out_bk_q.size() > 0;
            exp_bk_msg      = exp_bk_valid ? out_bk_q[0] : '0;
            exp_in_nb_valid = in_nb_q.size() > 0;
            exp_in_nb_msg   = exp_in_nb_valid ? in_nb_q[0] : '0;
            exp_in_bk_valid = in_bk_q.size() > 0;
            exp_in_bk_msg   = exp_in_bk_valid ? in_bk_q[0] : '0;
            in_count        = in_nb_q.size() + in_bk_q.size();  // Mirrors inbound FIFO occupancy
            in_flight       = in_count + out_nb_q.size() + out_bk_q.size();
        end
    end

    a_reset_state: assert property (@(posedge clk) disable iff (!rst_n)
        idle_phase |-> !master_out_valid && !neighbor_in_valid && !blocking_in_valid &&
                       !has_flying_messages && neighbor_out_ready && blocking_out_ready &&
                       master_in_ready)
        else abort_run("Outputs were not in their reset state after reset release");

    a_out_neighbor: assert property (@(posedge clk) disable iff (!rst_n)
        master_out_valid && master_out_ready && master_out_data.channel == msg_pkg::CH_NEIGHBOR
        |-> exp_nb_valid && master_out_data.msg == exp_nb_msg)
        else report_mismatch("master_out_data.msg", $sampled(exp_nb_msg),
                             $sampled(master_out_data.msg));

    a_out_blocking: assert property (@(posedge clk) disable iff (!rst_n)
        master_out_valid && master_out_ready && master_out_data.channel == msg_pkg::CH_BLOCKING
        |-> exp_bk_valid && master_out_data.msg == exp_bk_msg)
        else report_mismatch("master_out_data.msg", $sampled(exp_bk_msg),
                             $sampled(master_out_data.msg));

    a_in_neighbor: assert property (@(posedge clk) disable iff (!rst_n)
        neighbor_in_valid && neighbor_in_ready |-> exp_in_nb_valid &&
                                                   neighbor_in_data == exp_in_nb_msg)
        else report_mismatch("neighbor_in_data", $sampled(exp_in_nb_msg),
                             $sampled(neighbor_in_data));

    a_in_blocking: assert property (@(posedge clk) disable iff (!rst_n)
        blocking_in_valid && blocking_in_ready |-> exp_in_bk_valid &&
                                                   blocking_in_data == exp_in_bk_msg)
        else report_mismatch("blocking_in_data", $sampled(exp_in_bk_msg),
                             $sampled(blocking_in_data));

    a_one_inbound: assert property (@(posedge clk) disable iff (!rst_n)
        !(neighbor_in_valid && blocking_in_valid))
        else abort_run("Both inbound channels were valid in the same cycle");

    a_priority: assert property (@(posedge clk) disable iff (!rst_n)
        expect_neighbor_head && master_out_valid |-> master_out_data.channel == msg_pkg::CH_NEIGHBOR)
        else report_mismatch("master_out_data.channel", msg_pkg::CH_NEIGHBOR,
                             $sampled(master_out_data.channel));

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        latency_probe && ((neighbor_out_valid && neighbor_out_ready) ||
                          (blocking_out_valid && blocking_out_ready))
        |=> !master_out_valid ##1 master_out_valid)
        else abort_run("master_out_valid did not rise exactly two edges after the PU accept");

    a_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
        bp_check |-> !neighbor_out_ready && !blocking_out_ready)
        else abort_run("A PU ready stayed high while the master stream was stalled");

    a_head_blocks: assert property (@(posedge clk) disable iff (!rst_n)
        head_hold |-> neighbor_in_valid && !blocking_in_valid)
        else abort_run("A blocking word got past a stalled neighbor word at the inbound head");

    a_in_ready: assert property (@(posedge clk) disable iff (!rst_n)
        master_in_ready == (in_count != msg_pkg::MASTER_FIFO_DEPTH))
        else report_mismatch("master_in_ready", in_count != msg_pkg::MASTER_FIFO_DEPTH,
                             $sampled(master_in_ready));

    a_flying: assert property (@(posedge clk) disable iff (!rst_n)
        has_flying_messages == (in_flight != 0))
        else report_mismatch("has_flying_messages", $sampled(in_flight) != 0,
                             $sampled(has_flying_messages));

    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout, the link did not deliver all messages in the allowed time");
    end

    initial begin
        msg_pkg::master_word_t word;
        logic                  nb_fire;
        logic                  bk_fire;
        lfsr_state           = 32'h4519;
        rst_n                = 1'b0;
        neighbor_out_data    = '0;
        neighbor_out_valid   = 1'b0;
        blocking_out_data    = '0;
        blocking_out_valid   = 1'b0;
        neighbor_in_ready    = 1'b0;
        blocking_in_ready    = 1'b0;
        master_out_ready     = 1'b0;
        master_in_data       = '0;
        master_in_valid      = 1'b0;
        {exp_nb_valid, exp_bk_valid, exp_in_nb_valid, exp_in_bk_valid} = '0;
        {exp_nb_msg, exp_bk_msg, exp_in_nb_msg, exp_in_bk_msg} = '0;
        in_count             = 0;
        in_flight            = 0;
        idle_phase           = 1'b0;
        expect_neighbor_head = 1'b0;
        latency_probe        = 1'b0;
        bp_check             = 1'b0;
        head_hold            = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n      = 1'b1;
        idle_phase = 1'b1;
        repeat (4) @(negedge clk);
        idle_phase = 1'b0;

        master_out_ready = 1'b0;  // Both messages meet at a stalled FIFO
        send_outbound_pair(1'b1, 1'b1);
        expect_neighbor_head = 1'b1;
        repeat (4) @(negedge clk);
        wait_for_drain();

        latency_probe = 1'b1;
        send_outbound_pair(1'b1, 1'b0);
        wait_for_drain();
        send_outbound_pair(1'b0, 1'b1);
        wait_for_drain();
        latency_probe = 1'b0;

        master_out_ready   = 1'b0;
        neighbor_out_valid = 1'b1;
        neighbor_out_data  = random_msg();
        blocking_out_valid = 1'b1;
        blocking_out_data  = random_msg();
        repeat (BP_CYCLES) begin
            @(posedge clk);
            nb_fire = neighbor_out_valid && neighbor_out_ready;
            bk_fire = blocking_out_valid && blocking_out_ready;
            @(negedge clk);
            if (nb_fire) begin
                neighbor_out_data = random_msg();
            end
            if (bk_fire) begin
                blocking_out_data = random_msg();
            end
        end
        bp_check = 1'b1;
        @(negedge clk);
        bp_check = 1'b0;
        run_random_traffic(0, 0, 0);
        wait_for_drain();

        neighbor_in_ready = 1'b0;  // Stall the neighbor word that will sit at the head
        blocking_in_ready = 1'b1;
        word         = random_word();
        word.channel = msg_pkg::CH_NEIGHBOR;
        send_inbound_word(word);
        head_hold    = 1'b1;
        word         = random_word();
        word.channel = msg_pkg::CH_BLOCKING;
        send_inbound_word(word);
        repeat (HEAD_WORDS - 2) send_inbound_word(random_word());
        @(negedge clk);
        master_in_valid = 1'b0;
        repeat (3) @(negedge clk);
        head_hold = 1'b0;
        wait_for_drain();

        run_random_traffic(RANDOM_MSGS, RANDOM_MSGS, RANDOM_MSGS);
        wait_for_drain();
        if (in_flight == 0 && !has_flying_messages) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run("Messages were still held in the link at the end of the run");
        end
    end

endmodule

/* src.f */
decoder_pkg.sv
msg_pkg.sv
direct_msg_if.sv
fifo_fwft.sv
msg_skid.sv
pu_arbitration_unit.sv
pu_link_top.sv
tb_pu_link.sv

/* Bender.yml */
package:
  name: pu_link

sources:
  - decoder_pkg.sv
  - msg_pkg.sv
  - direct_msg_if.sv
  - fifo_fwft.sv
  - msg_skid.sv
  - pu_arbitration_unit.sv
  - pu_link_top.sv
  - target: simulation
    files:
      - tb_pu_link.sv
